/* addr_translate.sv */
`timescale 1ns/1ns

module addr_translate import rm_pkg::*; #(
  parameter int ADDR_W = ADDR_W_DEF
) (
  input  logic [ADDR_W-1:0] logical_addr,
  input  logic [ADDR_W-1:0] code_base,
  input  logic [ADDR_W-1:0] data_base,
  input  logic [ADDR_W-1:0] unmod_base,
  input  logic [ADDR_W-1:0] mem1_size,
  output logic [ADDR_W-1:0] phys_addr
);

  // region hits
  logic in_unmod;
  logic in_data;
  logic [ADDR_W-1:0] region_base;

  // unmodifiable region wins over the other two
  assign in_unmod = (logical_addr >= unmod_base);
  // above mem1 means data space
  assign in_data  = (logical_addr >= mem1_size);

  always_comb begin
    if (in_unmod) begin
      // absolute, no relocation
      region_base = '0;
    end else if (in_data) begin
      region_base = data_base;
    end else begin
      // low region is code space
      region_base = code_base;
    end
  end

  assign phys_addr = logical_addr + region_base;

endmodule

/* operand_regs.sv */
`timescale 1ns/1ns

module operand_regs import rm_pkg::*; #(
  parameter int DATA_W = DATA_W_DEF
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              op_start,
  // capture strobes from the sequencer
  input  logic              cap_result,
  input  logic              cap_ptr,
  input  logic              cap_read,
  input  logic              cap_read_p,
  input  logic [DATA_W-1:0] alu_result,
  input  logic [DATA_W-1:0] ptr_in,
  input  logic [DATA_W-1:0] rd_data,
  input  logic              is_ptr,
  input  logic [1:0]        reg_flags,
  // 1 for pointer write, 0 for register write
  input  logic              wr_ptr_form,
  output logic [DATA_W-1:0] result,
  output logic [DATA_W-1:0] ptr_value,
  output logic [DATA_W-1:0] wr_data
);

  // host operands sampled at start
  logic [DATA_W-1:0] alu_q;
  logic [DATA_W-1:0] ptr_in_q;
  logic              is_ptr_q;
  logic [1:0]        flags_q;
  // write word before adjust
  logic              sel_ptr;
  logic [DATA_W-1:0] save_word;

  always_ff @(posedge clk) begin
    if (op_start) begin
      alu_q    <= alu_result;
      ptr_in_q <= ptr_in;
      is_ptr_q <= is_ptr;
      flags_q  <= reg_flags;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result    <= '0;
      ptr_value <= '0;
    end else begin
      if (cap_result) begin
        result <= alu_q;
      end
      // pointer catch fills both
      if (cap_ptr) begin
        result    <= ptr_in_q;
        ptr_value <= ptr_in_q;
      end
      // plain register read also reloads the pointer
      if (cap_read) begin
        result    <= rd_data;
        ptr_value <= rd_data;
      end
      // read through pointer, pointer kept
      if (cap_read_p) begin
        result <= rd_data;
      end
    end
  end

  // selection flips for pointer writes
  assign sel_ptr   = wr_ptr_form ? !is_ptr_q : is_ptr_q;
  assign save_word = sel_ptr ? ptr_value : result;

  always_comb begin
    if (wr_ptr_form) begin
      // no post-adjust through a pointer
      wr_data = save_word;
    end else begin
      case (flags_q)
        flag_inc: wr_data = save_word + 1'b1;
        flag_dec: wr_data = save_word - 1'b1;
        default:  wr_data = save_word;
      endcase
    end
  end

endmodule

/* reg_op_sequencer.sv */
`timescale 1ns/1ns

module reg_op_sequencer import rm_pkg::*; #(
  parameter int ADDR_W    = ADDR_W_DEF,
  parameter int REG_NUM_W = REG_NUM_W_DEF
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 op_start,
  input  reg_op_t              op_code,
  input  logic [REG_NUM_W-1:0] reg_num,
  input  logic                 save_allowed,
  input  logic [ADDR_W-1:0]    ptr_value,
  input  logic [ADDR_W-1:0]    code_base,
  input  logic [ADDR_W-1:0]    data_base,
  input  logic [ADDR_W-1:0]    unmod_base,
  input  logic [ADDR_W-1:0]    mem1_size,
  output logic                 busy,
  output logic                 op_done,
  // to the bus port
  output logic                 bus_req,
  output logic                 bus_we,
  output logic [ADDR_W-1:0]    bus_addr,
  input  logic                 bus_resp,
  // to the operand regs
  output logic                 cap_result,
  output logic                 cap_ptr,
  output logic                 cap_read,
  output logic                 cap_read_p,
  output logic                 wr_ptr_form
);

  typedef enum logic [1:0] {
    s_idle,
    s_issue,
    s_wait,
    s_done
  } seq_state_t;

  seq_state_t state;

  // operation latched at start
  reg_op_t              op_q;
  logic [REG_NUM_W-1:0] reg_num_q;
  logic                 save_q;

  logic [ADDR_W-1:0] reg_logical;
  logic [ADDR_W-1:0] reg_read_addr;
  logic [ADDR_W-1:0] reg_phys;
  logic [ADDR_W-1:0] ptr_phys;
  logic [ADDR_W-1:0] next_addr;
  logic              is_write;
  logic              start_ok;

  assign start_ok = (state == s_idle) && op_start;
  assign is_write = (op_q == op_write) || (op_q == op_write_p);

  assign reg_logical = ADDR_W'(reg_num_q);
  // register reads go straight into data space
  assign reg_read_addr = data_base + reg_logical;

  // register write target
  addr_translate #(
    .ADDR_W(ADDR_W)
  ) u_reg_xlate (
    .logical_addr(reg_logical),
    .code_base   (code_base),
    .data_base   (data_base),
    .unmod_base  (unmod_base),
    .mem1_size   (mem1_size),
    .phys_addr   (reg_phys)
  );

  // target for both pointer ops
  addr_translate #(
    .ADDR_W(ADDR_W)
  ) u_ptr_xlate (
    .logical_addr(ptr_value),
    .code_base   (code_base),
    .data_base   (data_base),
    .unmod_base  (unmod_base),
    .mem1_size   (mem1_size),
    .phys_addr   (ptr_phys)
  );

  always_comb begin
    case (op_q)
      op_read:              next_addr = reg_read_addr;
      op_write:             next_addr = reg_phys;
      op_read_p, op_write_p: next_addr = ptr_phys;
      default:              next_addr = reg_read_addr;
    endcase
  end

  always_ff @(posedge clk) begin
    if (start_ok) begin
      op_q      <= op_code;
      reg_num_q <= reg_num;
      save_q    <= save_allowed;
    end
    if (state == s_issue) begin
      bus_addr <= next_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= s_idle;
      busy        <= 1'b0;
      op_done     <= 1'b0;
      bus_req     <= 1'b0;
      bus_we      <= 1'b0;
      cap_result  <= 1'b0;
      cap_ptr     <= 1'b0;
      cap_read    <= 1'b0;
      cap_read_p  <= 1'b0;
      wr_ptr_form <= 1'b0;
    end else begin
      // one-cycle pulses
      op_done    <= 1'b0;
      bus_req    <= 1'b0;
      cap_result <= 1'b0;
      cap_ptr    <= 1'b0;
      cap_read   <= 1'b0;
      cap_read_p <= 1'b0;
      case (state)
        s_idle: begin
          if (start_ok) begin
            busy        <= 1'b1;
            wr_ptr_form <= (op_code == op_write_p);
            state       <= s_issue;
          end
        end
        s_issue: begin
          if (op_q == op_catch_result) begin
            cap_result <= 1'b1;
            state      <= s_done;
          end else if (op_q == op_catch_ptr) begin
            cap_ptr <= 1'b1;
            state   <= s_done;
          end else if (is_write && !save_q) begin
            // blocked save, no bus cycle
            state <= s_done;
          end else begin
            bus_req <= 1'b1;
            bus_we  <= is_write;
            state   <= s_wait;
          end
        end
        s_wait: begin
          if (bus_resp) begin
            cap_read   <= (op_q == op_read);
            cap_read_p <= (op_q == op_read_p);
            state      <= s_done;
          end
        end
        default: begin
          // captures land on this same edge
          op_done <= 1'b1;
          busy    <= 1'b0;
          state   <= s_idle;
        end
      endcase
    end
  end

endmodule

/* register_manager.f */
rm_pkg.sv
addr_translate.sv
wb_master_port.sv
operand_regs.sv
reg_op_sequencer.sv
register_manager.sv
wb_mem_model.sv
tb_register_manager.sv

/* register_manager.sv */
`timescale 1ns/1ns

module register_manager import rm_pkg::*; #(
  parameter int ADDR_W    = ADDR_W_DEF,
  parameter int DATA_W    = DATA_W_DEF,
  parameter int REG_NUM_W = REG_NUM_W_DEF
) (
  input  logic                 clk,
  input  logic                 rst,
  // host command port
  input  logic                 op_start,
  input  reg_op_t              op_code,
  input  logic [REG_NUM_W-1:0] reg_num,
  input  logic                 is_ptr,
  input  logic [1:0]           reg_flags,
  input  logic                 save_allowed,
  input  logic [DATA_W-1:0]    alu_result,
  input  logic [DATA_W-1:0]    ptr_in,
  // static configuration
  input  logic [ADDR_W-1:0]    code_base,
  input  logic [ADDR_W-1:0]    data_base,
  input  logic [ADDR_W-1:0]    unmod_base,
  input  logic [ADDR_W-1:0]    mem1_size,
  output logic [DATA_W-1:0]    result,
  output logic [DATA_W-1:0]    ptr_value,
  output logic                 op_done,
  output logic                 busy,
  // wishbone master
  output logic                 wb_cyc,
  output logic                 wb_stb,
  output logic                 wb_we,
  output logic [ADDR_W-1:0]    wb_adr,
  output logic [DATA_W-1:0]    wb_dat_w,
  input  logic [DATA_W-1:0]    wb_dat_r,
  input  logic                 wb_ack
);

  logic              bus_req;
  logic              bus_we;
  logic [ADDR_W-1:0] bus_addr;
  logic              bus_resp;
  logic [DATA_W-1:0] rd_data;
  logic [DATA_W-1:0] wr_data;
  logic              cap_result;
  logic              cap_ptr;
  logic              cap_read;
  logic              cap_read_p;
  logic              wr_ptr_form;
  // pointer seen as an address
  logic [ADDR_W-1:0] ptr_addr;

  assign ptr_addr = ADDR_W'(ptr_value);

  reg_op_sequencer #(
    .ADDR_W   (ADDR_W),
    .REG_NUM_W(REG_NUM_W)
  ) u_reg_op_sequencer (
    .clk(clk), .rst(rst),
    .op_start(op_start), .op_code(op_code), .reg_num(reg_num),
    .save_allowed(save_allowed), .ptr_value(ptr_addr),
    .code_base(code_base), .data_base(data_base),
    .unmod_base(unmod_base), .mem1_size(mem1_size),
    .busy(busy), .op_done(op_done),
    .bus_req(bus_req), .bus_we(bus_we), .bus_addr(bus_addr), .bus_resp(bus_resp),
    .cap_result(cap_result), .cap_ptr(cap_ptr),
    .cap_read(cap_read), .cap_read_p(cap_read_p), .wr_ptr_form(wr_ptr_form)
  );

  // start pulse also samples the host operands
  operand_regs #(
    .DATA_W(DATA_W)
  ) u_operand_regs (
    .clk(clk), .rst(rst), .op_start(op_start && !busy),
    .cap_result(cap_result), .cap_ptr(cap_ptr),
    .cap_read(cap_read), .cap_read_p(cap_read_p),
    .alu_result(alu_result), .ptr_in(ptr_in), .rd_data(rd_data),
    .is_ptr(is_ptr), .reg_flags(reg_flags), .wr_ptr_form(wr_ptr_form),
    .result(result), .ptr_value(ptr_value), .wr_data(wr_data)
  );

  wb_master_port #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) u_wb_master_port (
    .clk(clk), .rst(rst),
    .bus_req(bus_req), .bus_we(bus_we), .bus_addr(bus_addr), .wr_data(wr_data),
    .rd_data(rd_data), .bus_resp(bus_resp),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

endmodule

/* rm_pkg.sv */
package rm_pkg;

  // host operation codes
  // catch ops load operand regs from the datapath, no bus traffic
  // read ops fetch one word over wishbone
  // write ops store one word, unless saving is blocked
  typedef enum logic [2:0] {
    op_catch_result = 3'd0,
    op_catch_ptr    = 3'd1,
    op_read         = 3'd2,
    op_read_p       = 3'd3,
    op_write        = 3'd4,
    op_write_p      = 3'd5
  } reg_op_t;

  // default widths, the top level passes them down
  parameter int ADDR_W_DEF = 16;
  parameter int DATA_W_DEF = 16;

  // 16 architectural registers in data memory
  parameter int REG_NUM_W_DEF = 4;

  // post-adjust encodings of reg_flags
  // 01 bumps the stored word up, 10 bumps it down
  // 00 and 11 leave it as is
  parameter logic [1:0] flag_inc = 2'b01;
  parameter logic [1:0] flag_dec = 2'b10;

endpackage

/* run.sh */
#!/bin/sh
# build and run the register manager testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert --top-module tb_register_manager \
  -f register_manager.f -Mdir obj_dir -o sim_register_manager
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_register_manager
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

/* tb_register_manager.sv */
`timescale 1ns/1ns

module tb_register_manager import rm_pkg::*; ();

  localparam int ADDR_W    = ADDR_W_DEF;
  localparam int DATA_W    = DATA_W_DEF;
  localparam int REG_NUM_W = REG_NUM_W_DEF;
  localparam int SEED      = 36461;
  // cycles allowed per operation
  localparam int TIMEOUT   = 40;
  // memory map inside the 1024 word model
  localparam logic [ADDR_W-1:0] CODE_BASE  = 16'h0100;
  localparam logic [ADDR_W-1:0] DATA_BASE  = 16'h0200;
  localparam logic [ADDR_W-1:0] UNMOD_BASE = 16'h0300;
  localparam logic [ADDR_W-1:0] MEM1_SIZE  = 16'h0008;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 op_start;
  reg_op_t              op_code;
  logic [REG_NUM_W-1:0] reg_num;
  logic                 is_ptr;
  logic [1:0]           reg_flags;
  logic                 save_allowed;
  logic [DATA_W-1:0]    alu_result;
  logic [DATA_W-1:0]    ptr_in;
  logic [ADDR_W-1:0]    code_base;
  logic [ADDR_W-1:0]    data_base;
  logic [ADDR_W-1:0]    unmod_base;
  logic [ADDR_W-1:0]    mem1_size;
  logic [DATA_W-1:0]    result;
  logic [DATA_W-1:0]    ptr_value;
  logic                 op_done;
  logic                 busy;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic [ADDR_W-1:0]    wb_adr;
  logic [DATA_W-1:0]    wb_dat_w;
  logic [DATA_W-1:0]    wb_dat_r;
  logic                 wb_ack;
  int                   wr_count;
  logic [ADDR_W-1:0]    last_wr_adr;
  logic [DATA_W-1:0]    last_wr_dat;

  // negedge index of first cyc, last ack and done within one op
  int                   cyc_k;
  int                   ack_k;
  int                   done_k;
  int                   seed;
  int                   cnt;
  logic [REG_NUM_W-1:0] rn;
  logic [DATA_W-1:0]    rv;
  logic [DATA_W-1:0]    pv;
  logic [DATA_W-1:0]    exp_word;
  logic [ADDR_W-1:0]    addr;
  logic                 ip;
  logic [1:0]           fl;

  always #50 clk = ~clk;

  register_manager #(
    .ADDR_W(ADDR_W), .DATA_W(DATA_W), .REG_NUM_W(REG_NUM_W)
  ) u_register_manager (
    .clk(clk), .rst(rst), .op_start(op_start), .op_code(op_code), .reg_num(reg_num),
    .is_ptr(is_ptr), .reg_flags(reg_flags), .save_allowed(save_allowed),
    .alu_result(alu_result), .ptr_in(ptr_in),
    .code_base(code_base), .data_base(data_base),
    .unmod_base(unmod_base), .mem1_size(mem1_size),
    .result(result), .ptr_value(ptr_value), .op_done(op_done), .busy(busy),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  wb_mem_model #(
    .ADDR_W(ADDR_W), .DATA_W(DATA_W), .SEED(SEED)
  ) u_mem_model (
    .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .wr_count(wr_count), .last_wr_adr(last_wr_adr), .last_wr_dat(last_wr_dat)
  );

  // request frozen while the slave stalls
  assert property (@(posedge clk) disable iff (rst)
    (wb_cyc && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_we)
                             && $stable(wb_dat_w)))
  else begin
    $display("ERR %0t wishbone request changed before ack", $time);
    $display("RESULT: FAIL");
    $fatal(1);
  end

  task automatic check_word(input string what, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    assert (got == exp) else begin
      $display("ERR %0t %s: got %h expected %h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_int(input string what, input int got, input int exp);
    assert (got == exp) else begin
      $display("ERR %0t %s: got %0d expected %0d", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_true(input string what, input bit cond);
    assert (cond) else begin
      $display("ERR %0t %s", $time, what);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  // three region translation
  function automatic logic [ADDR_W-1:0] xlate(input logic [ADDR_W-1:0] a);
    if (a >= UNMOD_BASE) begin
      return a;
    end else if (a >= MEM1_SIZE) begin
      return a + DATA_BASE;
    end
    return a + CODE_BASE;
  endfunction

  function automatic logic [DATA_W-1:0] post_adjust(input logic [DATA_W-1:0] v,
                                                   input logic [1:0] f);
    if (f == 2'b01) begin
      return v + DATA_W'(1);
    end else if (f == 2'b10) begin
      return v - DATA_W'(1);
    end
    return v;
  endfunction

  function automatic logic [DATA_W-1:0] mem_at(input logic [ADDR_W-1:0] a);
    return u_mem_model.mem[a[9:0]];
  endfunction

  // 0 low region, 1 data region, 2 unmodifiable
  function automatic logic [DATA_W-1:0] rand_ptr(input int region);
    logic [DATA_W-1:0] r;
    r = DATA_W'($random(seed));
    if (region == 0) begin
      return r & 16'h0007;
    end else if (region == 1) begin
      return 16'h0008 + (r % 16'h00f8);
    end
    return 16'h0300 | (r & 16'h00ff);
  endfunction

  // one host operation driven and sampled on falling edges
  task automatic run_op(input reg_op_t code, input logic [REG_NUM_W-1:0] r_num,
                        input logic ptr_sel, input logic [1:0] flags, input logic save,
                        input logic [DATA_W-1:0] alu, input logic [DATA_W-1:0] pin);
    int k;
    k = 0;
    cyc_k = 0;
    ack_k = 0;
    done_k = 0;
    @(negedge clk);
    op_code      = code;
    reg_num      = r_num;
    is_ptr       = ptr_sel;
    reg_flags    = flags;
    save_allowed = save;
    alu_result   = alu;
    ptr_in       = pin;
    op_start     = 1'b1;
    while (done_k == 0) begin
      @(negedge clk);
      k++;
      if (k == 1) begin
        op_start = 1'b0;
        check_true("busy low after op_start", busy);
      end
      check_true("wb_stb differs from wb_cyc", wb_stb == wb_cyc);
      // write enable follows the operation kind
      if (wb_cyc) begin
        check_true("wb_we wrong during bus cycle",
                   wb_we == ((code == op_write) || (code == op_write_p)));
      end
      if (wb_cyc && cyc_k == 0) begin
        cyc_k = k;
      end
      if (wb_ack) begin
        ack_k = k;
      end
      if (op_done) begin
        done_k = k;
      end else if (k >= TIMEOUT) begin
        $display("timeout, op_done did not arrive within %0d cycles", TIMEOUT);
        $display("RESULT: FAIL");
        $fatal(1);
      end
    end
    check_true("busy still high at op_done", !busy);
  endtask

  // negedge k follows rising edge k-1 after the start edge
  task automatic check_timing(input bit with_bus);
    if (with_bus) begin
      check_int("cyc rise", cyc_k, 3);
      check_true("no ack seen during bus op", ack_k > 0);
      check_int("op_done after ack", done_k - ack_k, 3);
    end else begin
      check_int("cyc during busless op", cyc_k, 0);
      check_int("op_done latency", done_k, 3);
    end
  endtask

  // pointer first since catch_ptr also fills result
  task automatic load_operands(input logic [DATA_W-1:0] p, input logic [DATA_W-1:0] v);
    run_op(op_catch_ptr, '0, 1'b0, 2'b00, 1'b0, '0, p);
    check_timing(1'b0);
    check_word("catch_ptr result", result, p);
    check_word("catch_ptr pointer", ptr_value, p);
    run_op(op_catch_result, '0, 1'b0, 2'b00, 1'b0, v, '0);
    check_timing(1'b0);
    check_word("catch_result result", result, v);
    check_word("catch_result pointer", ptr_value, p);
  endtask

  initial begin
    seed         = SEED;
    rst          = 1'b1;
    op_start     = 1'b0;
    op_code      = op_catch_result;
    reg_num      = '0;
    is_ptr       = 1'b0;
    reg_flags    = 2'b00;
    save_allowed = 1'b0;
    alu_result   = '0;
    ptr_in       = '0;
    code_base    = CODE_BASE;
    data_base    = DATA_BASE;
    unmod_base   = UNMOD_BASE;
    mem1_size    = MEM1_SIZE;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // quiet after reset
    @(negedge clk);
    check_true("wb_cyc high after reset", !wb_cyc);
    check_true("wb_stb high after reset", !wb_stb);
    check_true("wb_we high after reset", !wb_we);
    check_true("busy high after reset", !busy);
    check_true("op_done high after reset", !op_done);
    check_word("result after reset", result, '0);
    check_word("ptr_value after reset", ptr_value, '0);

    // catches and then register reads
    load_operands(DATA_W'($random(seed)), DATA_W'($random(seed)));
    for (int n = 0; n < 4; n++) begin
      rn = REG_NUM_W'($random(seed));
      exp_word = mem_at(DATA_BASE + ADDR_W'(rn));
      run_op(op_read, rn, 1'b0, 2'b00, 1'b0, '0, '0);
      check_timing(1'b1);
      check_word("op_read result", result, exp_word);
      check_word("op_read pointer", ptr_value, exp_word);
    end

    // pointer reads in each region
    for (int n = 0; n < 6; n++) begin
      pv = rand_ptr(n % 3);
      load_operands(pv, DATA_W'($random(seed)));
      exp_word = mem_at(xlate(pv));
      run_op(op_read_p, '0, 1'b0, 2'b00, 1'b0, '0, '0);
      check_timing(1'b1);
      check_word("op_read_p result", result, exp_word);
      check_word("op_read_p pointer", ptr_value, pv);
    end

    // register writes over every flag value and both selections
    for (int n = 0; n < 8; n++) begin
      fl = 2'(n / 2);
      ip = 1'(n % 2);
      rn = REG_NUM_W'($random(seed));
      pv = DATA_W'($random(seed));
      rv = DATA_W'($random(seed));
      load_operands(pv, rv);
      exp_word = post_adjust(ip ? pv : rv, fl);
      addr = xlate(ADDR_W'(rn));
      cnt = wr_count;
      run_op(op_write, rn, ip, fl, 1'b1, '0, '0);
      check_timing(1'b1);
      check_int("op_write count", wr_count, cnt + 1);
      check_word("op_write address", last_wr_adr, addr);
      check_word("op_write data", last_wr_dat, exp_word);
      check_word("op_write memory", mem_at(addr), exp_word);
    end

    // pointer writes with inverted selection and no adjust
    for (int n = 0; n < 6; n++) begin
      ip = 1'(n % 2);
      pv = rand_ptr(n / 2);
      rv = DATA_W'($random(seed));
      load_operands(pv, rv);
      exp_word = ip ? rv : pv;
      addr = xlate(pv);
      cnt = wr_count;
      run_op(op_write_p, REG_NUM_W'($random(seed)), ip, 2'($random(seed)), 1'b1, '0, '0);
      check_timing(1'b1);
      check_int("op_write_p count", wr_count, cnt + 1);
      check_word("op_write_p address", last_wr_adr, addr);
      check_word("op_write_p data", last_wr_dat, exp_word);
      check_word("op_write_p memory", mem_at(addr), exp_word);
    end

    // blocked saves leave memory alone
    for (int n = 0; n < 4; n++) begin
      rn = REG_NUM_W'($random(seed));
      pv = rand_ptr(n % 3);
      load_operands(pv, DATA_W'($random(seed)));
      addr = (n < 2) ? xlate(ADDR_W'(rn)) : xlate(pv);
      exp_word = mem_at(addr);
      cnt = wr_count;
      run_op((n < 2) ? op_write : op_write_p, rn, 1'(n), 2'b01, 1'b0, '0, '0);
      check_timing(1'b0);
      check_int("blocked save count", wr_count, cnt);
      check_word("blocked save memory", mem_at(addr), exp_word);
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* wb_master_port.sv */
`timescale 1ns/1ns

module wb_master_port import rm_pkg::*; #(
  parameter int ADDR_W = ADDR_W_DEF,
  parameter int DATA_W = DATA_W_DEF
) (
  input  logic              clk,
  input  logic              rst,
  // request side
  input  logic              bus_req,
  input  logic              bus_we,
  input  logic [ADDR_W-1:0] bus_addr,
  input  logic [DATA_W-1:0] wr_data,
  output logic [DATA_W-1:0] rd_data,
  output logic              bus_resp,
  // wishbone classic
  output logic              wb_cyc,
  output logic              wb_stb,
  output logic              wb_we,
  output logic [ADDR_W-1:0] wb_adr,
  output logic [DATA_W-1:0] wb_dat_w,
  input  logic [DATA_W-1:0] wb_dat_r,
  input  logic              wb_ack
);

  // transfer ends on the edge that samples ack
  logic xfer_end;
  // new request accepted only with the bus idle
  logic xfer_start;

  assign xfer_end   = wb_cyc && wb_ack;
  assign xfer_start = !wb_cyc && bus_req;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_cyc   <= 1'b0;
      wb_stb   <= 1'b0;
      wb_we    <= 1'b0;
      bus_resp <= 1'b0;
    end else begin
      bus_resp <= 1'b0;
      if (xfer_end) begin
        // drop the cycle right after ack
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        bus_resp <= 1'b1;
      end else if (xfer_start) begin
        // cyc and stb rise together
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= bus_we;
      end
    end
  end

  // address and write word held for the whole cycle
  always_ff @(posedge clk) begin
    if (xfer_start) begin
      wb_adr   <= bus_addr;
      wb_dat_w <= wr_data;
    end
  end

  // read word kept until the next read
  always_ff @(posedge clk) begin
    if (xfer_end && !wb_we) begin
      rd_data <= wb_dat_r;
    end
  end

endmodule

/* wb_mem_model.sv */
`timescale 1ns/1ns

module wb_mem_model import rm_pkg::*; #(
  parameter int ADDR_W = ADDR_W_DEF,
  parameter int DATA_W = DATA_W_DEF,
  parameter int SEED   = 1
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [ADDR_W-1:0] wb_adr,
  input  logic [DATA_W-1:0] wb_dat_w,
  output logic [DATA_W-1:0] wb_dat_r,
  output logic              wb_ack,
  // write log
  output int                wr_count,
  output logic [ADDR_W-1:0] last_wr_adr,
  output logic [DATA_W-1:0] last_wr_dat
);

  localparam int DEPTH = 1024;

  logic [DATA_W-1:0] mem [DEPTH];
  // wait state draw for the current request
  int                seed = SEED;
  logic              active;
  logic [1:0]        wait_left;
  logic [1:0]        draw;
  logic              go;
  logic [9:0]        idx;

  assign idx = wb_adr[9:0];

  always @(posedge clk) begin
    if (rst) begin
      // odd multiplier, every word differs from every other
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= DATA_W'(i) * DATA_W'(16'h9e37) + DATA_W'(16'h3c5a);
      end
      wb_ack    <= 1'b0;
      active    <= 1'b0;
      wait_left <= 2'd0;
      wr_count  <= 0;
    end else begin
      wb_ack <= 1'b0;
      go = 1'b0;
      if (wb_cyc && wb_stb && !wb_ack) begin
        if (!active) begin
          // 0 to 3 extra cycles before ack
          draw = 2'($random(seed));
          go = (draw == 2'd0);
          active    <= !go;
          wait_left <= draw - 2'd1;
        end else begin
          go = (wait_left == 2'd0);
          active    <= !go;
          wait_left <= wait_left - 2'd1;
        end
      end
      if (go) begin
        wb_ack <= 1'b1;
        if (wb_we) begin
          mem[idx]    <= wb_dat_w;
          wr_count    <= wr_count + 1;
          last_wr_adr <= wb_adr;
          last_wr_dat <= wb_dat_w;
        end else begin
          wb_dat_r <= mem[idx];
        end
      end
    end
  end

endmodule
